// File: execCore.f
+incdir+include
hw/execPkg.sv
hw/aluCore.sv
hw/branchCond.sv
hw/operandRead.sv
hw/executeStage.sv
hw/writeBack.sv
hw/execTop.sv
test/clockGen.sv
test/exec_properties.sv
test/execTb.sv

// File: run.sh
#!/bin/sh
# build the execute core testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module execTb -f execCore.f

status=0
./obj_dir/VexecTb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Test completed successfully" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: test/execTb.sv
// execTb
// random testbench for the execute pipeline, checks every result and
// branch report against an architectural model in issue order
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module execTb;

   localparam int ClkPeriod = 10;
   localparam int ClearOps  = 16;
   localparam int RandOps   = 300;
   localparam int DepOps    = 200;
   localparam int BrOps     = 200;
   localparam int HaltOps   = 60;
   localparam int TotalOps  = ClearOps + RandOps + DepOps + BrOps + HaltOps;

   typedef struct packed {
      int               cycle;     // issue cycle
      execPkg::regIdx_t idx;
      execPkg::word_t   data;
      logic             brValid;
      logic             brTaken;
      execPkg::word_t   pcNext;
   } expOp_t;

   logic             clk;
   logic             rstN;
   logic             issueValid;
   execPkg::regIdx_t rsIdx;
   execPkg::regIdx_t rtIdx;
   execPkg::regIdx_t rdIdx;
   execPkg::word_t   imm;
   logic             bSrc;
   execPkg::aluOp_t  aluOp;
   logic             invA;
   logic             invB;
   logic             cin;
   execPkg::brCode_t brCode;
   logic             aluJmp;
   execPkg::word_t   pc;
   logic             halt;
   logic             issueReady;
   logic             resValid;
   execPkg::regIdx_t resIdx;
   execPkg::word_t   resData;
   logic             brValid;
   logic             brTaken;
   execPkg::word_t   pcNext;

   logic [31:0]    lfsrState;
   int             cycle;
   int             checks;
   int             errors;
   int             startChecks;
   int             startErrors;
   execPkg::word_t model [`EXEC_REG_N];   // architectural registers
   expOp_t         resQ[$];
   expOp_t         brQ[$];

   clockGen clkGen (
      .clk  (clk),
      .rstN (rstN)
   );

   execTop DUT (
      .clk        (clk),
      .rstN       (rstN),
      .issueValid (issueValid),
      .rsIdx      (rsIdx),
      .rtIdx      (rtIdx),
      .rdIdx      (rdIdx),
      .imm        (imm),
      .bSrc       (bSrc),
      .aluOp      (aluOp),
      .invA       (invA),
      .invB       (invB),
      .cin        (cin),
      .brCode     (brCode),
      .aluJmp     (aluJmp),
      .pc         (pc),
      .halt       (halt),
      .issueReady (issueReady),
      .resValid   (resValid),
      .resIdx     (resIdx),
      .resData    (resData),
      .brValid    (brValid),
      .brTaken    (brTaken),
      .pcNext     (pcNext)
   );

   bind executeStage execProperties props (
      .clk     (clk),
      .rstN    (rstN),
      .s1Valid (s1Valid),
      .s1Halt  (s1Halt),
      .s2Valid (s2Valid),
      .brValid (brValid),
      .brTaken (brTaken)
   );

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic [15:0] randBits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsrState = lfsrStep(lfsrState);   // one step per bit
         v = {v[14:0], lfsrState[0]};
      end
      return v;
   endfunction

   function automatic execPkg::word_t modelAlu(input logic [2:0] op, input execPkg::word_t a,
                                               input execPkg::word_t b, input logic c);
      logic [16:0]    sum;
      logic [31:0]    ext;
      int             sh;
      execPkg::word_t r;
      sh  = int'(b[3:0]);
      sum = 17'(a) + 17'(b) + 17'(c);
      ext = {{16{a[15]}}, a} >> sh;   // sign-filled shift
      case (op)
         `EXEC_ALU_ADD: r = sum[15:0];
         `EXEC_ALU_AND: r = a & b;
         `EXEC_ALU_OR:  r = a | b;
         `EXEC_ALU_XOR: r = a ^ b;
         `EXEC_ALU_SLL: r = a << sh;
         `EXEC_ALU_SRL: r = a >> sh;
         `EXEC_ALU_SRA: r = ext[15:0];
         default:       r = b;
      endcase
      return r;
   endfunction

   function automatic logic modelCond(input logic [2:0] code, input execPkg::word_t res);
      case (code)
         `EXEC_BR_EQ:     return res == 16'd0;
         `EXEC_BR_NE:     return res != 16'd0;
         `EXEC_BR_LT:     return res[15];
         `EXEC_BR_GE:     return !res[15];
         `EXEC_BR_ALWAYS: return 1'b1;
         default:         return 1'b0;
      endcase
   endfunction

   task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   task automatic checkOutputs();
      expOp_t e;
      if (resQ.size() > 0 && resQ[0].cycle + 3 == cycle) begin
         e = resQ.pop_front();
         checkEq("resValid", resValid, 1);
         checkEq("resIdx", resIdx, e.idx);
         checkEq("resData", resData, e.data);
      end else begin
         checkEq("resValid with nothing due", resValid, 0);
      end
      if (brQ.size() > 0 && brQ[0].cycle + 2 == cycle) begin
         e = brQ.pop_front();
         checkEq("brValid", brValid, e.brValid);
         checkEq("brTaken", brTaken, e.brTaken);
         if (e.brValid) begin
            checkEq("pcNext", pcNext, e.pcNext);
         end
      end else begin
         checkEq("brValid with nothing due", brValid, 0);
         checkEq("brTaken with nothing due", brTaken, 0);
      end
   endtask

   // outputs are checked at the falling edge, then inputs are driven
   task automatic tick();
      @(negedge clk);
      cycle++;
      checkOutputs();
   endtask

   task automatic idleInputs();
      issueValid = 1'b0;
      rsIdx      = '0;
      rtIdx      = '0;
      rdIdx      = '0;
      imm        = '0;
      bSrc       = 1'b0;
      aluOp      = `EXEC_ALU_ADD;
      invA       = 1'b0;
      invB       = 1'b0;
      cin        = 1'b0;
      brCode     = `EXEC_BR_NONE;
      aluJmp     = 1'b0;
      pc         = '0;
      halt       = 1'b0;
   endtask

   task automatic randomizeInputs();
      idleInputs();
      rsIdx = 3'(randBits(3));
      rtIdx = 3'(randBits(3));
      rdIdx = 3'(randBits(3));
      imm   = randBits(16);
      bSrc  = 1'(randBits(1));
      aluOp = 3'(randBits(3));
      invA  = 1'(randBits(1));
      invB  = 1'(randBits(1));
      cin   = 1'(randBits(1));
      pc    = randBits(16);
   endtask

   // issues what is on the inputs and runs it through the model
   task automatic issueCurrent();
      execPkg::word_t a;
      execPkg::word_t b;
      execPkg::word_t res;
      logic           taken;
      expOp_t         e;
      a     = invA ? ~model[rsIdx] : model[rsIdx];
      b     = bSrc ? imm : model[rtIdx];
      b     = invB ? ~b : b;
      res   = modelAlu(aluOp, a, b, cin);
      taken = !halt && modelCond(brCode, res);
      e.cycle   = cycle;
      e.idx     = rdIdx;
      e.data    = res;
      e.brValid = (brCode != `EXEC_BR_NONE) || aluJmp;
      e.brTaken = taken;
      e.pcNext  = aluJmp ? res : (taken ? pc + imm : pc + 16'd1);
      model[rdIdx] = res;
      issueValid   = 1'b1;
      resQ.push_back(e);
      brQ.push_back(e);
   endtask

   task automatic drain();
      repeat (5) begin
         tick();
         idleInputs();
      end
   endtask

   task automatic beginTest();
      startChecks = checks;
      startErrors = errors;
   endtask

   task automatic endTest(input string name);
      $display("%s: %0d checks, %0d errors", name, checks - startChecks, errors - startErrors);
   endtask

   task automatic testClear();
      int clearCycles;
      beginTest();
      while (rstN !== 1'b1) begin
         tick();
         checkEq("issueReady in reset", issueReady, 0);
      end
      clearCycles = 1;   // first clear edge comes before this sample
      while (issueReady !== 1'b1) begin
         randomizeInputs();
         issueValid = 1'b1;   // must be dropped during the clear
         tick();
         clearCycles++;
      end
      idleInputs();
      checkEq("clear cycles", clearCycles, `EXEC_REG_N);
      for (int i = 0; i < `EXEC_REG_N; i++) begin
         tick();
         idleInputs();
         aluOp = `EXEC_ALU_PASSB;
         rtIdx = 3'(i);
         rdIdx = 3'(i);
         issueCurrent();
         tick();
         idleInputs();
         bSrc  = 1'b1;          // reg + imm 0
         rsIdx = 3'(i);
         rdIdx = 3'(i);
         issueCurrent();
      end
      drain();
      endTest("test 1 reset and clear");
   endtask

   task automatic testRandomAlu();
      beginTest();
      repeat (RandOps) begin
         tick();
         randomizeInputs();
         if (randBits(2) != 16'd0) begin
            issueCurrent();
         end
      end
      drain();
      endTest("test 2 random ALU");
   endtask

   task automatic testDependent();
      execPkg::regIdx_t prev1;
      execPkg::regIdx_t prev2;
      beginTest();
      prev1 = 3'd0;
      prev2 = 3'd1;
      repeat (DepOps) begin
         tick();
         randomizeInputs();
         rsIdx = (randBits(1) != 16'd0) ? prev1 : prev2;
         rtIdx = (randBits(1) != 16'd0) ? prev1 : prev2;
         bSrc  = (randBits(2) == 16'd0);
         issueCurrent();
         prev2 = prev1;
         prev1 = rdIdx;
      end
      drain();
      endTest("test 3 dependent chains");
   endtask

   task automatic testBranches(input int n, input logic haltOn, input string name);
      beginTest();
      repeat (n) begin
         tick();
         randomizeInputs();
         brCode = 3'(randBits(3) % 16'd6);
         aluJmp = (randBits(2) == 16'd0);
         halt   = haltOn;
         if (randBits(2) == 16'd0) begin
            rtIdx = rsIdx;            // x ^ x gives a zero result
            bSrc  = 1'b0;
            aluOp = `EXEC_ALU_XOR;
            invA  = 1'b0;
            invB  = 1'b0;
         end
         issueCurrent();
      end
      drain();
      endTest(name);
   endtask

   initial begin
      #((TotalOps * 10 + 200) * ClkPeriod);
      $display("watchdog timeout: the tests did not finish in the allowed time");
      $display("Test failed");
      $finish;
   end

   initial begin
      lfsrState = 32'hcfc8f4e9;
      cycle     = 0;
      checks    = 0;
      errors    = 0;
      for (int i = 0; i < `EXEC_REG_N; i++) begin
         model[i] = '0;
      end
      idleInputs();
      testClear();
      testRandomAlu();
      testDependent();
      testBranches(BrOps, 1'b0, "test 4 branch conditions");
      testBranches(HaltOps, 1'b1, "test 5 halt");
      $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: test/exec_properties.sv
// execProperties
// assertions bound into executeStage: slot advance, halt suppressing
// branches, and quiet outputs during reset
`timescale 1ns/1ps
`default_nettype none

module execProperties (
   input wire clk,
   input wire rstN,
   input wire s1Valid,
   input wire s1Halt,
   input wire s2Valid,
   input wire brValid,
   input wire brTaken
);

   // every slot moves from stage 1 to stage 2 in exactly one cycle
   slotAdvance: assert property (@(posedge clk) disable iff (!rstN)
      s1Valid |=> s2Valid)
      else $error("stage-2 valid missing one cycle after stage-1 valid");

   noGhostSlot: assert property (@(posedge clk) disable iff (!rstN)
      !s1Valid |=> !s2Valid)
      else $error("stage-2 valid without a stage-1 operation");

   haltNoBranch: assert property (@(posedge clk) disable iff (!rstN)
      (s1Valid && s1Halt) |=> !brTaken)
      else $error("branch taken while halt was applied");

   // synchronous reset clears the valid outputs on the next edge
   resetQuiet: assert property (@(posedge clk)
      !rstN |=> (!s2Valid && !brValid && !brTaken))
      else $error("valid output high during reset");

endmodule

`default_nettype wire

// File: test/clockGen.sv
// clockGen
// testbench clock with a 10 ns period and an active-low reset held
// for the first two clock cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
   parameter int HalfPeriod  = 5,
   parameter int ResetCycles = 2
) (
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #HalfPeriod clk = ~clk;
   end

   initial begin
      rstN <= 1'b0;
      repeat (ResetCycles) @(posedge clk);
      @(negedge clk);
      rstN <= 1'b1;   // released on a falling edge like the other inputs
   end

endmodule

`default_nettype wire

// File: hw/execTop.sv
// execTop
// three-stage execute pipeline: operand read, execute, writeback
// fixed three-cycle latency from issue to result
`timescale 1ns/1ps
`default_nettype none

module execTop (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire                   issueValid,
   input  wire execPkg::regIdx_t rsIdx,
   input  wire execPkg::regIdx_t rtIdx,
   input  wire execPkg::regIdx_t rdIdx,
   input  wire execPkg::word_t   imm,
   input  wire                   bSrc,
   input  wire execPkg::aluOp_t  aluOp,
   input  wire                   invA,
   input  wire                   invB,
   input  wire                   cin,
   input  wire execPkg::brCode_t brCode,
   input  wire                   aluJmp,
   input  wire execPkg::word_t   pc,
   input  wire                   halt,
   output logic                  issueReady,
   output logic                  resValid,
   output execPkg::regIdx_t      resIdx,
   output execPkg::word_t        resData,
   output logic                  brValid,
   output logic                  brTaken,
   output execPkg::word_t        pcNext
);

   logic             s1Valid;
   execPkg::word_t   s1A;
   execPkg::word_t   s1B;
   execPkg::word_t   s1Imm;
   execPkg::word_t   s1Pc;
   execPkg::regIdx_t s1Rd;
   execPkg::fwdSel_t fwdA;
   execPkg::fwdSel_t fwdB;
   logic             s1BSrc;
   execPkg::aluOp_t  s1AluOp;
   logic             s1InvA;
   logic             s1InvB;
   logic             s1Cin;
   execPkg::brCode_t s1BrCode;
   logic             s1AluJmp;
   logic             s1Halt;
   logic             s2Valid;
   execPkg::regIdx_t s2Rd;
   execPkg::word_t   s2Data;
   logic             wrEn;
   execPkg::regIdx_t wrIdx;
   execPkg::word_t   wrData;

   operandRead opRd (
      .clk        (clk),
      .rstN       (rstN),
      .issueValid (issueValid),
      .rsIdx      (rsIdx),
      .rtIdx      (rtIdx),
      .rdIdx      (rdIdx),
      .imm        (imm),
      .pc         (pc),
      .bSrc       (bSrc),
      .aluOp      (aluOp),
      .invA       (invA),
      .invB       (invB),
      .cin        (cin),
      .brCode     (brCode),
      .aluJmp     (aluJmp),
      .halt       (halt),
      .wrEn       (wrEn),
      .wrIdx      (wrIdx),
      .wrData     (wrData),
      .s2Valid    (s2Valid),
      .s2Rd       (s2Rd),
      .issueReady (issueReady),
      .s1Valid    (s1Valid),
      .s1A        (s1A),
      .s1B        (s1B),
      .s1Imm      (s1Imm),
      .s1Pc       (s1Pc),
      .s1Rd       (s1Rd),
      .fwdA       (fwdA),
      .fwdB       (fwdB),
      .s1BSrc     (s1BSrc),
      .s1AluOp    (s1AluOp),
      .s1InvA     (s1InvA),
      .s1InvB     (s1InvB),
      .s1Cin      (s1Cin),
      .s1BrCode   (s1BrCode),
      .s1AluJmp   (s1AluJmp),
      .s1Halt     (s1Halt)
   );

   // stage-2 and writeback results loop back as forwarding sources
   executeStage exStg (
      .clk      (clk),
      .rstN     (rstN),
      .s1Valid  (s1Valid),
      .s1A      (s1A),
      .s1B      (s1B),
      .s1Imm    (s1Imm),
      .s1Pc     (s1Pc),
      .s1Rd     (s1Rd),
      .fwdA     (fwdA),
      .fwdB     (fwdB),
      .s1BSrc   (s1BSrc),
      .s1AluOp  (s1AluOp),
      .s1InvA   (s1InvA),
      .s1InvB   (s1InvB),
      .s1Cin    (s1Cin),
      .s1BrCode (s1BrCode),
      .s1AluJmp (s1AluJmp),
      .s1Halt   (s1Halt),
      .exFwd    (s2Data),
      .wbFwd    (resData),
      .s2Valid  (s2Valid),
      .s2Rd     (s2Rd),
      .s2Data   (s2Data),
      .brValid  (brValid),
      .brTaken  (brTaken),
      .pcNext   (pcNext)
   );

   writeBack wbStg (
      .clk      (clk),
      .rstN     (rstN),
      .s2Valid  (s2Valid),
      .s2Rd     (s2Rd),
      .s2Data   (s2Data),
      .wrEn     (wrEn),
      .wrIdx    (wrIdx),
      .wrData   (wrData),
      .resValid (resValid),
      .resIdx   (resIdx),
      .resData  (resData)
   );

endmodule

`default_nettype wire

// File: hw/writeBack.sv
// writeBack
// stage 3 commit register, feeds the register file write port and the
// result ports
`timescale 1ns/1ps
`default_nettype none

module writeBack (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire                   s2Valid,
   input  wire execPkg::regIdx_t s2Rd,
   input  wire execPkg::word_t   s2Data,
   output logic                  wrEn,
   output execPkg::regIdx_t      wrIdx,
   output execPkg::word_t        wrData,
   output logic                  resValid,
   output execPkg::regIdx_t      resIdx,
   output execPkg::word_t        resData
);

   logic             cmtValid;
   execPkg::regIdx_t cmtIdx;
   execPkg::word_t   cmtData;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         cmtValid <= 1'b0;
      end else begin
         cmtValid <= s2Valid;
      end
   end

   always_ff @(posedge clk) begin
      cmtIdx  <= s2Rd;
      cmtData <= s2Data;
   end

   // every valid op writes, register 0 included
   assign wrEn   = cmtValid;
   assign wrIdx  = cmtIdx;
   assign wrData = cmtData;

   assign resValid = cmtValid;   // one cycle per committed op
   assign resIdx   = cmtIdx;
   assign resData  = cmtData;

endmodule

`default_nettype wire

// File: hw/executeStage.sv
// executeStage
// stage 2: forwarding and B-source muxes, ALU, branch logic and the
// stage-2 register that carries the result and the next PC
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module executeStage (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire                   s1Valid,
   input  wire execPkg::word_t   s1A,
   input  wire execPkg::word_t   s1B,
   input  wire execPkg::word_t   s1Imm,
   input  wire execPkg::word_t   s1Pc,
   input  wire execPkg::regIdx_t s1Rd,
   input  wire execPkg::fwdSel_t fwdA,
   input  wire execPkg::fwdSel_t fwdB,
   input  wire                   s1BSrc,
   input  wire execPkg::aluOp_t  s1AluOp,
   input  wire                   s1InvA,
   input  wire                   s1InvB,
   input  wire                   s1Cin,
   input  wire execPkg::brCode_t s1BrCode,
   input  wire                   s1AluJmp,
   input  wire                   s1Halt,
   input  wire execPkg::word_t   exFwd,      // stage-2 result
   input  wire execPkg::word_t   wbFwd,      // writeback result
   output logic                  s2Valid,
   output execPkg::regIdx_t      s2Rd,
   output execPkg::word_t        s2Data,
   output logic                  brValid,
   output logic                  brTaken,
   output execPkg::word_t        pcNext
);

   execPkg::word_t opA;
   execPkg::word_t opRt;
   execPkg::word_t opB;
   execPkg::word_t aluOut;
   execPkg::word_t pcNextC;
   logic           zf;
   logic           sf;
   logic           brTakenC;
   logic           isFlow;

   function automatic execPkg::word_t fwdMux(
      input execPkg::fwdSel_t sel,
      input execPkg::word_t   rf,
      input execPkg::word_t   ex,
      input execPkg::word_t   wb
   );
      case (sel)
         `EXEC_FWD_EX: return ex;
         `EXEC_FWD_WB: return wb;
         default:      return rf;
      endcase
   endfunction

   assign opA  = fwdMux(fwdA, s1A, exFwd, wbFwd);
   assign opRt = fwdMux(fwdB, s1B, exFwd, wbFwd);
   assign opB  = s1BSrc ? s1Imm : opRt;   // immediate or register

   aluCore alu (
      .inA    (opA),
      .inB    (opB),
      .cin    (s1Cin),
      .aluOp  (s1AluOp),
      .invA   (s1InvA),
      .invB   (s1InvB),
      .aluOut (aluOut),
      .zf     (zf),
      .sf     (sf),
      .ovf    (),
      .cf     ()
   );

   branchCond brCtl (
      .pc      (s1Pc),
      .imm     (s1Imm),
      .aluOut  (aluOut),
      .zf      (zf),
      .sf      (sf),
      .brCode  (s1BrCode),
      .aluJmp  (s1AluJmp),
      .halt    (s1Halt),
      .valid   (s1Valid),
      .brTaken (brTakenC),
      .pcNext  (pcNextC)
   );

   // only branches and jumps report a PC
   assign isFlow = s1Valid && ((s1BrCode != `EXEC_BR_NONE) || s1AluJmp);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         s2Valid <= 1'b0;
         brValid <= 1'b0;
         brTaken <= 1'b0;
      end else begin
         s2Valid <= s1Valid;
         brValid <= isFlow;
         brTaken <= brTakenC;
      end
   end

   always_ff @(posedge clk) begin
      s2Rd   <= s1Rd;
      s2Data <= aluOut;
      pcNext <= pcNextC;
   end

endmodule

`default_nettype wire

// File: hw/operandRead.sv
// operandRead
// stage 1 of the execute pipeline: register file with a clear sequence
// after reset, source reads with write bypass, forwarding select generation
// and the stage-1 pipeline register
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module operandRead (
   input  wire                   clk,
   input  wire                   rstN,
   input  wire                   issueValid,
   input  wire execPkg::regIdx_t rsIdx,
   input  wire execPkg::regIdx_t rtIdx,
   input  wire execPkg::regIdx_t rdIdx,
   input  wire execPkg::word_t   imm,
   input  wire execPkg::word_t   pc,
   input  wire                   bSrc,
   input  wire execPkg::aluOp_t  aluOp,
   input  wire                   invA,
   input  wire                   invB,
   input  wire                   cin,
   input  wire execPkg::brCode_t brCode,
   input  wire                   aluJmp,
   input  wire                   halt,
   input  wire                   wrEn,
   input  wire execPkg::regIdx_t wrIdx,
   input  wire execPkg::word_t   wrData,
   input  wire                   s2Valid,   // current stage-2 occupant
   input  wire execPkg::regIdx_t s2Rd,
   output logic                  issueReady,
   output logic                  s1Valid,
   output execPkg::word_t        s1A,
   output execPkg::word_t        s1B,
   output execPkg::word_t        s1Imm,
   output execPkg::word_t        s1Pc,
   output execPkg::regIdx_t      s1Rd,
   output execPkg::fwdSel_t      fwdA,
   output execPkg::fwdSel_t      fwdB,
   output logic                  s1BSrc,
   output execPkg::aluOp_t       s1AluOp,
   output logic                  s1InvA,
   output logic                  s1InvB,
   output logic                  s1Cin,
   output execPkg::brCode_t      s1BrCode,
   output logic                  s1AluJmp,
   output logic                  s1Halt
);

   execPkg::word_t    regFile [`EXEC_REG_N];
   execPkg::opState_t state;
   execPkg::regIdx_t  clrIdx;
   execPkg::word_t    rsData;
   execPkg::word_t    rtData;
   execPkg::fwdSel_t  selA;
   execPkg::fwdSel_t  selB;
   logic              accept;

   // newest producer wins: stage 1 now is stage 2 next cycle
   function automatic execPkg::fwdSel_t pickFwd(
      input execPkg::regIdx_t src,
      input logic             exValid,
      input execPkg::regIdx_t exRd,
      input logic             wbValid,
      input execPkg::regIdx_t wbRd
   );
      if (exValid && (exRd == src)) begin
         return `EXEC_FWD_EX;
      end else if (wbValid && (wbRd == src)) begin
         return `EXEC_FWD_WB;
      end
      return `EXEC_FWD_RF;
   endfunction

   assign issueReady = (state == execPkg::ST_RUN);
   assign accept     = issueValid && issueReady;   // dropped while clearing

   // clear sequence walks every register once
   always_ff @(posedge clk) begin
      if (!rstN) begin
         state  <= execPkg::ST_CLEAR;
         clrIdx <= '0;
      end else if (state == execPkg::ST_CLEAR) begin
         clrIdx <= clrIdx + 1'b1;
         if (clrIdx == `EXEC_REG_W'(`EXEC_REG_N - 1)) begin
            state <= execPkg::ST_RUN;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == execPkg::ST_CLEAR) begin
         regFile[clrIdx] <= '0;
      end else if (wrEn) begin
         regFile[wrIdx] <= wrData;
      end
   end

   // a write on this edge is seen by the read
   assign rsData = (wrEn && (wrIdx == rsIdx)) ? wrData : regFile[rsIdx];
   assign rtData = (wrEn && (wrIdx == rtIdx)) ? wrData : regFile[rtIdx];

   assign selA = pickFwd(rsIdx, s1Valid, s1Rd, s2Valid, s2Rd);
   assign selB = pickFwd(rtIdx, s1Valid, s1Rd, s2Valid, s2Rd);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         s1Valid <= 1'b0;
      end else begin
         s1Valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      s1A      <= rsData;
      s1B      <= rtData;
      s1Imm    <= imm;
      s1Pc     <= pc;
      s1Rd     <= rdIdx;
      fwdA     <= selA;
      fwdB     <= selB;
      s1BSrc   <= bSrc;
      s1AluOp  <= aluOp;
      s1InvA   <= invA;
      s1InvB   <= invB;
      s1Cin    <= cin;
      s1BrCode <= brCode;
      s1AluJmp <= aluJmp;
      s1Halt   <= halt;
   end

endmodule

`default_nettype wire

// File: hw/branchCond.sv
// branchCond
// branch condition on the ALU flags, PC-relative target and next-PC choice
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module branchCond (
   input  wire execPkg::word_t   pc,
   input  wire execPkg::word_t   imm,
   input  wire execPkg::word_t   aluOut,
   input  wire                   zf,
   input  wire                   sf,
   input  wire execPkg::brCode_t brCode,
   input  wire                   aluJmp,
   input  wire                   halt,
   input  wire                   valid,
   output logic                  brTaken,
   output execPkg::word_t        pcNext
);

   logic           condMet;
   execPkg::word_t target;
   execPkg::word_t pcInc;

   always_comb begin
      case (brCode)
         `EXEC_BR_EQ:     condMet = zf;
         `EXEC_BR_NE:     condMet = !zf;
         `EXEC_BR_LT:     condMet = sf;    // sign of the compare result
         `EXEC_BR_GE:     condMet = !sf;
         `EXEC_BR_ALWAYS: condMet = 1'b1;
         default:         condMet = 1'b0;  // NONE and unused codes
      endcase
   end

   // halted or empty slots never branch
   assign brTaken = valid && !halt && condMet;

   assign target = pc + imm;
   assign pcInc  = pc + execPkg::word_t'(1);

   // register jump beats a taken branch
   assign pcNext = aluJmp ? aluOut : (brTaken ? target : pcInc);

endmodule

`default_nettype wire

// File: hw/aluCore.sv
// aluCore
// combinational word ALU with operand inversion and carry-in
// subtract is ADD with invB and cin set
`timescale 1ns/1ps
`default_nettype none

`include "exec_settings.svh"

module aluCore (
   input  wire execPkg::word_t  inA,
   input  wire execPkg::word_t  inB,
   input  wire                  cin,
   input  wire execPkg::aluOp_t aluOp,
   input  wire                  invA,
   input  wire                  invB,
   output execPkg::word_t       aluOut,
   output logic                 zf,
   output logic                 sf,
   output logic                 ovf,
   output logic                 cf
);

   localparam int ShW  = $clog2(`EXEC_WORD_W);   // shift amount bits
   localparam int SumW = `EXEC_WORD_W + 1;

   execPkg::word_t  opA;
   execPkg::word_t  opB;
   logic [SumW-1:0] sumExt;

   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;

   // extra top bit holds the carry out
   assign sumExt = {1'b0, opA} + {1'b0, opB} + SumW'(cin);

   always_comb begin
      aluOut = opB;
      ovf    = 1'b0;
      cf     = 1'b0;
      case (aluOp)
         `EXEC_ALU_ADD: begin
            aluOut = sumExt[`EXEC_WORD_W-1:0];
            cf     = sumExt[`EXEC_WORD_W];
            // same-sign operands giving a result of the other sign
            ovf    = (opA[`EXEC_WORD_W-1] == opB[`EXEC_WORD_W-1]) &&
                     (sumExt[`EXEC_WORD_W-1] != opA[`EXEC_WORD_W-1]);
         end
         `EXEC_ALU_AND: aluOut = opA & opB;
         `EXEC_ALU_OR:  aluOut = opA | opB;
         `EXEC_ALU_XOR: aluOut = opA ^ opB;
         `EXEC_ALU_SLL: aluOut = opA << opB[ShW-1:0];
         `EXEC_ALU_SRL: aluOut = opA >> opB[ShW-1:0];
         `EXEC_ALU_SRA: aluOut = execPkg::word_t'($signed(opA) >>> opB[ShW-1:0]);
         default:       aluOut = opB;   // PASSB
      endcase
   end

   assign zf = (aluOut == '0);
   assign sf = aluOut[`EXEC_WORD_W-1];

endmodule

`default_nettype wire

// File: hw/execPkg.sv
// execute core types
// data word, register index, operation codes, forwarding select and the
// register file clear state
`default_nettype none

`include "exec_settings.svh"

package execPkg;

   // one machine word
   typedef logic [`EXEC_WORD_W-1:0] word_t;

   typedef logic [`EXEC_REG_W-1:0] regIdx_t;   // register file index

   // carries one of the EXEC_ALU_* codes
   typedef logic [2:0] aluOp_t;

   typedef logic [2:0] brCode_t;   // one of the EXEC_BR_* codes

   // operand source: register file, execute result or writeback result
   typedef logic [1:0] fwdSel_t;

   // register file clear after reset, then normal operation
   typedef enum logic {
      ST_CLEAR,
      ST_RUN
   } opState_t;

endpackage

`default_nettype wire

// File: include/exec_settings.svh
// execute core settings
// word and register file sizes, ALU operation codes, branch codes and
// forwarding select codes shared by the pipeline stages
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

`define EXEC_WORD_W 16
`define EXEC_REG_N  8
`define EXEC_REG_W  3

// ALU operations
`define EXEC_ALU_ADD   3'd0
`define EXEC_ALU_AND   3'd1
`define EXEC_ALU_OR    3'd2
`define EXEC_ALU_XOR   3'd3
`define EXEC_ALU_SLL   3'd4
`define EXEC_ALU_SRL   3'd5
`define EXEC_ALU_SRA   3'd6
`define EXEC_ALU_PASSB 3'd7

// branch conditions, codes 6 and 7 never branch
`define EXEC_BR_NONE   3'd0
`define EXEC_BR_EQ     3'd1
`define EXEC_BR_NE     3'd2
`define EXEC_BR_LT     3'd3
`define EXEC_BR_GE     3'd4
`define EXEC_BR_ALWAYS 3'd5

`define EXEC_FWD_RF 2'd0   // register file
`define EXEC_FWD_EX 2'd1   // execute result
`define EXEC_FWD_WB 2'd2   // writeback result

`endif
